/* tb.f */
+incdir+hdl
hdl/rr_pkg.sv
hdl/regfile.sv
hdl/load_use_hazard.sv
hdl/forward_capture.sv
hdl/reg_ex_stage.sv
hdl/issue_read_top.sv
tests/issue_read_sva.sv
tests/tb_issue_read.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the issue/read stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f tb.f --top-module tb_issue_read \
    -Mdir obj_dir -o sim_issue_read
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

./obj_dir/sim_issue_read > sim.log 2>&1
status=$?
cat sim.log

# a simulator abort counts as a failed run
if [ $status -ne 0 ]; then
    echo "*** FAILED ***" >> sim.log
fi

if grep -qF "*** FAILED ***" sim.log; then
    echo "simulation failed"
    exit 1
fi
echo "simulation passed"
exit 0

/* tests/tb_issue_read.sv */
`timescale 1ns/1ns
`include "rr_defines.svh"

module tb_issue_read
    import rr_pkg::*;
();

    localparam int WAIT_LIMIT = 50;

    logic        clk;
    logic        aresetn;
    logic        flush;
    logic        flush_by_priv;
    logic        forward_stall;
    logic        stall_d;
    logic        id_readygo;
    logic        ex_allowin;
    issue_pkt_t  id_pkt;
    wb_bundle_t  wb;
    fwd_bundle_t fwd;
    logic        reg_allowin;
    logic        ex_readygo;
    rr_out_t     ex_pkt;

    logic [31:0] rng;
    word_t       shadow [`RR_NREGS];
    int          errors;
    int          timeouts;
    int          tests_run;
    int          errs_at_start;

    issue_read_top dut (.*);

    always #20 clk = ~clk;

    function logic [31:0] next_rand();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    function issue_pkt_t rand_pkt();
        logic [351:0] raw;
        issue_pkt_t   p;
        raw = '0;
        for (int i = 0; i < 11; i++) begin
            raw = {raw[319:0], next_rand()};
        end
        p = raw[$bits(issue_pkt_t)-1:0];
        // no memory ops in random pairs
        p.slot0.uop.mem = 1'b0;
        p.slot1.uop.mem = 1'b0;
        return p;
    endfunction

    // expected register read including same-cycle write bypass
    function word_t expect_read(reg_addr_t a);
        word_t v;
        v = shadow[a];
        for (int w = 0; w < 3; w++) begin
            if (wb.port[w].we && wb.port[w].addr == a) begin
                v = wb.port[w].data;
            end
        end
        if (a == '0) begin
            v = '0;
        end
        return v;
    endfunction

    task automatic check_word(string name, word_t got, word_t exp);
        assert (got === exp) else begin
            errors++;
            $display("ERR t=%0t %s got %h exp %h", $time, name, got, exp);
        end
    endtask

    task automatic check_bubble(string where);
        rr_out_t b;
        b = '0;
        b.pkt.slot0.inst = `RR_INST_NOP;
        b.pkt.slot1.inst = `RR_INST_NOP;
        assert (ex_pkt === b) else begin
            errors++;
            $display("ERR t=%0t ex_pkt (%s) got %h exp %h", $time, where, ex_pkt, b);
        end
    endtask

    // advance one clock and apply this edge's writes to the shadow
    task automatic step();
        @(posedge clk);
        for (int w = 0; w < 3; w++) begin
            if (wb.port[w].we && wb.port[w].addr != '0) begin
                shadow[wb.port[w].addr] = wb.port[w].data;
            end
        end
        #2;
    endtask

    task automatic wait_allowin();
        int n;
        n = 0;
        #1;
        while (!reg_allowin && n < WAIT_LIMIT) begin
            step();
            n++;
        end
        if (!reg_allowin) begin
            timeouts++;
            errors++;
            $display("timeout: reg_allowin never went high at %0t", $time);
        end
    endtask

    // hands one pair to the stage, then holds EX back
    task automatic accept_one(issue_pkt_t p, logic do_wb);
        word_t exp_ops [4];
        reg_addr_t srcs [4];
        word_t r;
        id_pkt = p;
        id_readygo = 1'b1;
        ex_allowin = 1'b1;
        forward_stall = 1'b0;
        wait_allowin();
        srcs = '{p.slot0.rj, p.slot0.rk, p.slot1.rj, p.slot1.rk};
        if (do_wb) begin
            for (int w = 0; w < 3; w++) begin
                r = next_rand();
                wb.port[w].we = r[0];
                r = next_rand();
                if (r[1:0] == 2'd0) begin
                    wb.port[w].addr = r[6:2];
                end else begin
                    wb.port[w].addr = srcs[r[4:3]];
                end
                wb.port[w].data = next_rand();
            end
        end
        #1;
        for (int i = 0; i < 4; i++) begin
            exp_ops[i] = expect_read(srcs[i]);
        end
        step();
        wb = '0;
        id_readygo = 1'b0;
        ex_allowin = 1'b0;
        assert (ex_pkt.pkt === p) else begin
            errors++;
            $display("ERR t=%0t ex_pkt.pkt got %h exp %h", $time, ex_pkt.pkt, p);
        end
        check_word("ex_pkt.rj0", ex_pkt.rj0, exp_ops[0]);
        check_word("ex_pkt.rk0", ex_pkt.rk0, exp_ops[1]);
        check_word("ex_pkt.rj1", ex_pkt.rj1, exp_ops[2]);
        check_word("ex_pkt.rk1", ex_pkt.rk1, exp_ops[3]);
    endtask

    task automatic begin_test();
        errs_at_start = errors;
        tests_run++;
    endtask

    task automatic end_test(string name);
        $display("test %0d %s: %s", tests_run, name,
                 (errors == errs_at_start) ? "ok" : "errors");
    endtask

    initial begin
        issue_pkt_t p;
        rr_out_t    held;
        opnd_vec_t  d;
        clk = 1'b0;
        aresetn = 1'b0;
        flush = 1'b0;
        flush_by_priv = 1'b0;
        forward_stall = 1'b0;
        stall_d = 1'b0;
        id_readygo = 1'b0;
        ex_allowin = 1'b0;
        id_pkt = '0;
        wb = '0;
        fwd = '0;
        rng = 32'd29851;
        errors = 0;
        timeouts = 0;
        tests_run = 0;
        for (int i = 0; i < `RR_NREGS; i++) begin
            shadow[i] = '0;
        end
        repeat (10) @(posedge clk);
        #2;
        aresetn = 1'b1;

        begin_test();
        for (int i = 0; i < 4; i++) begin
            check_bubble("after reset");
            step();
        end
        end_test("reset bubble");

        begin_test();
        for (int i = 0; i < 30; i++) begin
            accept_one(rand_pkt(), 1'b1);
        end
        p = rand_pkt();
        p.slot0.rj = '0;
        accept_one(p, 1'b1);
        end_test("accept and read");

        begin_test();
        accept_one(rand_pkt(), 1'b0);
        flush_by_priv = 1'b1;
        step();
        flush_by_priv = 1'b0;
        check_bubble("flush_by_priv");
        accept_one(rand_pkt(), 1'b0);
        flush = 1'b1;
        stall_d = 1'b0;
        step();
        flush = 1'b0;
        check_bubble("flush");
        accept_one(rand_pkt(), 1'b0);
        ex_allowin = 1'b1;
        id_readygo = 1'b0;
        step();
        ex_allowin = 1'b0;
        check_bubble("ex take without pair");
        end_test("flush and bubble");

        begin_test();
        p = rand_pkt();
        p.slot0.uop.mem = 1'b1;
        p.slot0.uop.ctrl.lsu.store = 1'b0;
        p.slot0.rd = 5'd5;
        accept_one(p, 1'b0);
        p = rand_pkt();
        p.slot1.rk = 5'd5;
        id_pkt = p;
        id_readygo = 1'b1;
        ex_allowin = 1'b1;
        #1;
        assert (reg_allowin === 1'b0) else begin
            errors++;
            $display("ERR t=%0t reg_allowin got %b exp 0 (load in EX)", $time, reg_allowin);
        end
        step();
        #1;
        assert (reg_allowin === 1'b0) else begin
            errors++;
            $display("ERR t=%0t reg_allowin got %b exp 0 (load left EX)", $time, reg_allowin);
        end
        step();
        #1;
        assert (reg_allowin === 1'b1) else begin
            errors++;
            $display("ERR t=%0t reg_allowin got %b exp 1 (hazard gone)", $time, reg_allowin);
        end
        // EX busy with a forward, the pair has to wait
        forward_stall = 1'b1;
        #1;
        assert (reg_allowin === 1'b0) else begin
            errors++;
            $display("ERR t=%0t reg_allowin got %b exp 0 (forward stall)", $time, reg_allowin);
        end
        step();
        forward_stall = 1'b0;
        id_readygo = 1'b0;
        ex_allowin = 1'b0;
        end_test("load-use stall");

        begin_test();
        accept_one(rand_pkt(), 1'b0);
        held = ex_pkt;
        stall_d = 1'b1;
        fwd.flag = 4'b0001;
        for (int i = 0; i < 4; i++) begin
            fwd.data[i] = next_rand();
        end
        d = fwd.data;
        step();
        check_word("ex_pkt.rj0", ex_pkt.rj0, d[0]);
        check_word("ex_pkt.rk0", ex_pkt.rk0, held.rk0);
        // sticky j0 keeps following while j1 joins
        fwd.flag = 4'b0100;
        for (int i = 0; i < 4; i++) begin
            fwd.data[i] = next_rand();
        end
        d = fwd.data;
        step();
        check_word("ex_pkt.rj0", ex_pkt.rj0, d[0]);
        check_word("ex_pkt.rk0", ex_pkt.rk0, held.rk0);
        check_word("ex_pkt.rj1", ex_pkt.rj1, d[2]);
        check_word("ex_pkt.rk1", ex_pkt.rk1, held.rk1);
        stall_d = 1'b0;
        fwd.flag = 4'b0000;
        fwd.data[0] = next_rand();
        step();
        check_word("ex_pkt.rj0", ex_pkt.rj0, d[0]);
        stall_d = 1'b1;
        fwd.data[0] = next_rand();
        step();
        check_word("ex_pkt.rj0", ex_pkt.rj0, d[0]);
        assert (ex_pkt.pkt === held.pkt) else begin
            errors++;
            $display("ERR t=%0t ex_pkt.pkt got %h exp %h", $time, ex_pkt.pkt, held.pkt);
        end
        stall_d = 1'b0;
        fwd = '0;
        step();
        end_test("hold and forward");

        $display("tests: %0d, errors: %0d, timeouts: %0d", tests_run, errors, timeouts);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

/* tests/issue_read_sva.sv */
`timescale 1ns/1ns
`include "rr_defines.svh"

module issue_read_sva
    import rr_pkg::*;
(
    input logic        clk,
    input logic        aresetn,
    input logic        flush,
    input logic        flush_by_priv,
    input logic        forward_stall,
    input logic        stall_d,
    input logic        id_readygo,
    input logic        ex_allowin,
    input issue_pkt_t  id_pkt,
    input fwd_bundle_t fwd,
    input logic        reg_allowin,
    input logic        ex_readygo,
    input rr_out_t     ex_pkt
);

    logic      accept;
    logic      flushing;
    logic      hold;
    opnd_vec_t ops;

    function automatic logic is_bubble(rr_out_t p);
        rr_out_t b;
        b = '0;
        b.pkt.slot0.inst = `RR_INST_NOP;
        b.pkt.slot1.inst = `RR_INST_NOP;
        return p == b;
    endfunction

    assign accept   = id_readygo && reg_allowin && ex_allowin;
    assign flushing = flush_by_priv || (flush && !stall_d);
    // no acceptance, no flush and EX not draining
    assign hold     = !accept && !flushing && !(ex_allowin && !forward_stall);
    assign ops      = {ex_pkt.rj0, ex_pkt.rk0, ex_pkt.rj1, ex_pkt.rk1};

    a_readygo: assert property (@(posedge clk) disable iff (!aresetn)
        ex_readygo == !forward_stall) else $error("ex_readygo mismatch");

    a_allowin: assert property (@(posedge clk) disable iff (!aresetn)
        reg_allowin |-> (ex_allowin && !forward_stall)) else $error("reg_allowin too high");

    a_flush: assert property (@(posedge clk) disable iff (!aresetn)
        flushing |=> is_bubble(ex_pkt)) else $error("no bubble after flush");

    a_accept: assert property (@(posedge clk) disable iff (!aresetn)
        (accept && !flushing) |=> ex_pkt.pkt == $past(id_pkt)) else $error("pair not taken");

    a_hold: assert property (@(posedge clk) disable iff (!aresetn)
        hold |=> $stable(ex_pkt.pkt)) else $error("held pair changed");

    // operand order in ops is reversed against fwd.data
    for (genvar i = 0; i < 4; i++) begin : g_opnd
        a_fwd: assert property (@(posedge clk) disable iff (!aresetn)
            hold |=> (ops[3-i] == $past(ops[3-i]))
                     || ($past(stall_d) && ops[3-i] == $past(fwd.data[i])))
            else $error("operand changed without forward");
    end

endmodule

bind issue_read_top issue_read_sva u_sva (.*);

/* hdl/issue_read_top.sv */
`timescale 1ns/1ns

module issue_read_top
    import rr_pkg::*;
(
    input  logic        clk,
    input  logic        aresetn,
    input  logic        flush,
    input  logic        flush_by_priv,
    input  logic        forward_stall,
    input  logic        stall_d,
    input  logic        id_readygo,
    input  logic        ex_allowin,
    input  issue_pkt_t  id_pkt,
    input  wb_bundle_t  wb,
    input  fwd_bundle_t fwd,
    output logic        reg_allowin,
    output logic        ex_readygo,
    output rr_out_t     ex_pkt
);

    // register-read stage between ID and EX
    reg_ex_stage u_stage (
        .clk           (clk),
        .aresetn       (aresetn),
        .flush         (flush),
        .flush_by_priv (flush_by_priv),
        .forward_stall (forward_stall),
        .stall_d       (stall_d),
        .id_readygo    (id_readygo),
        .ex_allowin    (ex_allowin),
        .id_pkt        (id_pkt),
        .wb            (wb),
        .fwd           (fwd),
        .reg_allowin   (reg_allowin),
        .ex_readygo    (ex_readygo),
        .ex_pkt        (ex_pkt)
    );

endmodule

/* hdl/reg_ex_stage.sv */
`timescale 1ns/1ns
`include "rr_defines.svh"

module reg_ex_stage
    import rr_pkg::*;
(
    input  logic        clk,
    input  logic        aresetn,
    input  logic        flush,
    input  logic        flush_by_priv,
    input  logic        forward_stall,
    input  logic        stall_d,
    input  logic        id_readygo,
    input  logic        ex_allowin,
    input  issue_pkt_t  id_pkt,
    input  wb_bundle_t  wb,
    input  fwd_bundle_t fwd,
    output logic        reg_allowin,
    output logic        ex_readygo,
    output rr_out_t     ex_pkt
);

    rr_out_t   ex_q;
    src_addr_t src;
    word_t     rd_j0;
    word_t     rd_k0;
    word_t     rd_j1;
    word_t     rd_k1;
    opnd_vec_t cur_ops;
    opnd_vec_t next_ops;
    logic      hz_stall;
    logic      ex_take;
    logic      accept;
    logic      load_bubble;

    function automatic rr_out_t bubble_pkt();
        rr_out_t b;
        b = '0;
        b.pkt.slot0.inst = `RR_INST_NOP;
        b.pkt.slot1.inst = `RR_INST_NOP;
        return b;
    endfunction

    assign src.j0 = id_pkt.slot0.rj;
    assign src.k0 = id_pkt.slot0.rk;
    assign src.j1 = id_pkt.slot1.rj;
    assign src.k1 = id_pkt.slot1.rk;

    regfile u_regfile (
        .clk     (clk),
        .aresetn (aresetn),
        .wb      (wb),
        .ra_j0   (src.j0),
        .ra_k0   (src.k0),
        .ra_j1   (src.j1),
        .ra_k1   (src.k1),
        .rd_j0   (rd_j0),
        .rd_k0   (rd_k0),
        .rd_j1   (rd_j1),
        .rd_k1   (rd_k1)
    );

    load_use_hazard u_hazard (
        .clk      (clk),
        .aresetn  (aresetn),
        .ex_slot0 (ex_q.pkt.slot0),
        .ex_take  (ex_take),
        .src      (src),
        .stall    (hz_stall)
    );

    assign cur_ops[0] = ex_q.rj0;
    assign cur_ops[1] = ex_q.rk0;
    assign cur_ops[2] = ex_q.rj1;
    assign cur_ops[3] = ex_q.rk1;

    forward_capture u_fwd (
        .clk      (clk),
        .aresetn  (aresetn),
        .stall_d  (stall_d),
        .fwd      (fwd),
        .cur_ops  (cur_ops),
        .next_ops (next_ops)
    );

    // handshake with ID and EX
    assign ex_readygo  = !forward_stall;
    assign ex_take     = ex_allowin && ex_readygo;
    assign reg_allowin = ex_allowin && !forward_stall && !hz_stall;
    assign accept      = id_readygo && reg_allowin && ex_allowin;

    // EX drains while nothing valid comes in, so feed it a NOP pair
    assign load_bubble = flush_by_priv
                       || (flush && !stall_d)
                       || (ex_take && (!id_readygo || !reg_allowin));

    always_ff @(posedge clk or negedge aresetn) begin
        if (!aresetn) begin
            ex_q <= bubble_pkt();
        end else if (load_bubble) begin
            ex_q <= bubble_pkt();
        end else if (accept) begin
            ex_q.pkt <= id_pkt;
            ex_q.rj0 <= rd_j0;
            ex_q.rk0 <= rd_k0;
            ex_q.rj1 <= rd_j1;
            ex_q.rk1 <= rd_k1;
        end else begin
            // held pair, only operands may pick up forwarded values
            ex_q.rj0 <= next_ops[0];
            ex_q.rk0 <= next_ops[1];
            ex_q.rj1 <= next_ops[2];
            ex_q.rk1 <= next_ops[3];
        end
    end

    assign ex_pkt = ex_q;

endmodule

/* hdl/forward_capture.sv */
`timescale 1ns/1ns

module forward_capture
    import rr_pkg::*;
(
    input  logic        clk,
    input  logic        aresetn,
    input  logic        stall_d,
    input  fwd_bundle_t fwd,
    input  opnd_vec_t   cur_ops,
    output opnd_vec_t   next_ops
);

    logic [3:0] sticky;

    // remember which operands got forwarded during this hold
    always_ff @(posedge clk or negedge aresetn) begin
        if (!aresetn) begin
            sticky <= '0;
        end else if (!stall_d) begin
            sticky <= '0;
        end else begin
            sticky <= sticky | fwd.flag;
        end
    end

    // the forward data keeps updating while the hold lasts
    always_comb begin
        for (int i = 0; i < 4; i++) begin
            if (stall_d && (fwd.flag[i] || sticky[i])) begin
                next_ops[i] = fwd.data[i];
            end else begin
                next_ops[i] = cur_ops[i];
            end
        end
    end

endmodule

/* hdl/load_use_hazard.sv */
`timescale 1ns/1ns

module load_use_hazard
    import rr_pkg::*;
(
    input  logic      clk,
    input  logic      aresetn,
    input  slot_t     ex_slot0,
    input  logic      ex_take,
    input  src_addr_t src,
    output logic      stall
);

    logic      ex_is_load;
    reg_addr_t ex_load_rd;
    reg_addr_t shadow_rd;

    function automatic logic src_hit(src_addr_t s, reg_addr_t r);
        return (r != '0) && ((s.j0 == r) || (s.k0 == r) || (s.j1 == r) || (s.k1 == r));
    endfunction

    // memory op that is not a store
    assign ex_is_load = ex_slot0.uop.mem && !ex_slot0.uop.ctrl.lsu.store;
    assign ex_load_rd = ex_is_load ? ex_slot0.rd : '0;

    // load that just left EX, its data is not back yet
    always_ff @(posedge clk or negedge aresetn) begin
        if (!aresetn) begin
            shadow_rd <= '0;
        end else if (ex_take) begin
            shadow_rd <= ex_load_rd;
        end
    end

    assign stall = src_hit(src, ex_load_rd) || src_hit(src, shadow_rd);

endmodule

/* hdl/regfile.sv */
`timescale 1ns/1ns
`include "rr_defines.svh"

module regfile
    import rr_pkg::*;
(
    input  logic       clk,
    input  logic       aresetn,
    input  wb_bundle_t wb,
    input  reg_addr_t  ra_j0,
    input  reg_addr_t  ra_k0,
    input  reg_addr_t  ra_j1,
    input  reg_addr_t  ra_k1,
    output word_t      rd_j0,
    output word_t      rd_k0,
    output word_t      rd_j1,
    output word_t      rd_k1
);

    word_t regs [`RR_NREGS];

    logic [3:0][REG_AW-1:0] ra;
    opnd_vec_t              rdata;

    assign ra[0] = ra_j0;
    assign ra[1] = ra_k0;
    assign ra[2] = ra_j1;
    assign ra[3] = ra_k1;

    // later ports overwrite earlier ones in the same cycle
    always_ff @(posedge clk or negedge aresetn) begin
        if (!aresetn) begin
            for (int i = 0; i < `RR_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else begin
            for (int w = 0; w < 3; w++) begin
                if (wb.port[w].we && (wb.port[w].addr != '0)) begin
                    regs[wb.port[w].addr] <= wb.port[w].data;
                end
            end
        end
    end

    // write-through, highest port checked last so it wins
    always_comb begin
        for (int p = 0; p < 4; p++) begin
            rdata[p] = regs[ra[p]];
            for (int w = 0; w < 3; w++) begin
                if (wb.port[w].we && (wb.port[w].addr == ra[p])) begin
                    rdata[p] = wb.port[w].data;
                end
            end
            // r0 is hardwired
            if (ra[p] == '0) begin
                rdata[p] = '0;
            end
        end
    end

    assign rd_j0 = rdata[0];
    assign rd_k0 = rdata[1];
    assign rd_j1 = rdata[2];
    assign rd_k1 = rdata[3];

endmodule

/* hdl/rr_pkg.sv */
`include "rr_defines.svh"

package rr_pkg;

    localparam int REG_AW = $clog2(`RR_NREGS);
    localparam int UOP_FUNC_W = `RR_UOP_W - `RR_UOP_CLS_W - `RR_UOP_CTRL_W;

    typedef logic [`RR_XLEN-1:0] word_t;
    typedef logic [REG_AW-1:0] reg_addr_t;

    // condition field, read as load/store control or as branch compare
    typedef union packed {
        struct packed {
            logic       unsgn;
            logic       store;
            logic [1:0] size;
        } lsu;
        struct packed {
            logic [`RR_UOP_CTRL_W-1:0] cmp;
        } bru;
    } uop_ctrl_u;

    typedef struct packed {
        logic                  alu;
        logic                  mem;
        logic                  branch;
        logic                  syscall;
        logic                  brk;
        logic                  priv;
        uop_ctrl_u             ctrl;
        logic [UOP_FUNC_W-1:0] func;
    } uop_t;

    typedef struct packed {
        word_t     pc;
        word_t     inst;
        uop_t      uop;
        word_t     imm;
        reg_addr_t rj;
        reg_addr_t rk;
        reg_addr_t rd;
    } slot_t;

    typedef struct packed {
        slot_t                 slot0;
        slot_t                 slot1;
        word_t                 pc_next;
        logic                  pc_taken;
        logic                  branch_flag;
        logic                  excp_flag;
        logic [`RR_EXCP_W-1:0] excp_code;
        word_t                 badv;
    } issue_pkt_t;

    typedef struct packed {
        issue_pkt_t pkt;
        word_t      rj0;
        word_t      rk0;
        word_t      rj1;
        word_t      rk1;
    } rr_out_t;

    typedef struct packed {
        logic      we;
        reg_addr_t addr;
        word_t     data;
    } wb_port_t;

    // port 2 has the highest priority
    typedef struct packed {
        wb_port_t [2:0] port;
    } wb_bundle_t;

    // index 0..3 is j0, k0, j1, k1
    typedef logic [3:0][`RR_XLEN-1:0] opnd_vec_t;

    typedef struct packed {
        logic [3:0] flag;
        opnd_vec_t  data;
    } fwd_bundle_t;

    typedef struct packed {
        reg_addr_t j0;
        reg_addr_t k0;
        reg_addr_t j1;
        reg_addr_t k1;
    } src_addr_t;

endpackage

/* hdl/rr_defines.svh */
`ifndef RR_DEFINES_SVH
`define RR_DEFINES_SVH

// architectural register file
`define RR_NREGS 32
`define RR_XLEN 32

// micro-op field layout: class bits, condition field, function code
`define RR_UOP_W 16
`define RR_UOP_CLS_W 6
`define RR_UOP_CTRL_W 4

// andi r0, r0, 0
`define RR_INST_NOP 32'h0340_0000

// exception code width carried with the pair
`define RR_EXCP_W 7

`endif
